// ==== tb.f ====
design/tsc_pkg.sv
design/pipeline_control.sv
design/fetch_unit.sv
design/register_file.sv
design/execute_unit.sv
design/cpu_core.sv
dv/cpu_core_chk.sv
dv/tb_cpu_core.sv

// ==== dv/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    import tsc_pkg::*;

    localparam int num_random     = 60;
    localparam int prog_len       = num_random + 5;    // Four WWDs and HLT
    localparam int timeout_cycles = 2000;
    localparam int mem_words      = 256;

    logic  clk;
    logic  reset_n;
    word_t inst_data;
    word_t inst_addr;
    logic  read_inst;
    word_t output_port;
    word_t num_inst;
    logic  is_halted;

    word_t       imem [mem_words];
    word_t       model_regs [num_regs];
    logic [31:0] lcg_state = 32'd97674;
    int          errors = 0;
    int          timeouts = 0;

    cpu_core i_cpu_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_data   (inst_data),
        .inst_addr   (inst_addr),
        .read_inst   (read_inst),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    bind cpu_core cpu_core_chk i_cpu_core_chk (
        .clk       (clk),
        .reset_n   (reset_n),
        .inst_addr (inst_addr),
        .read_inst (read_inst),
        .num_inst  (num_inst),
        .is_halted (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Instruction memory answers for the current address
    task automatic next_cycle();
        @(posedge clk);
        #2;
        inst_data = imem[inst_addr[7:0]];
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program generation
    task automatic build_program();
        logic [31:0] r1;
        logic [31:0] r2;
        int          kind;
        int          i;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        reg_addr_t   prev_dst;
        logic [7:0]  imm8;
        opcode_e     op;
        prev_dst = 2'd0;
        for (i = 0; i < mem_words; i++)
            imem[i] = {8'h00, 8'(i)};   // Opcode 0, a no-op
        for (i = 0; i < num_random; i++) begin
            r1   = lcg_next();
            r2   = lcg_next();
            kind = r1[31:20] % 12;
            rs   = r1[19:18];
            rt   = r2[21:20];
            rd   = r2[23:22];
            imm8 = r2[31:24];
            if (r2[19])
                rs = prev_dst;          // Lean on the last result
            if (r2[18])
                rt = prev_dst;
            if (kind < 8) begin
                imem[i]  = {op_rtype, rs, rt, rd, 6'(kind)};
                prev_dst = rd;
            end else if (kind < 11) begin
                op       = (kind == 8) ? op_adi : (kind == 9) ? op_ori : op_lhi;
                imem[i]  = {op, rs, rt, imm8};
                prev_dst = rt;
            end else begin
                imem[i] = {op_rtype, rs, 2'b00, 2'b00, fn_wwd};
            end
        end
        for (i = 0; i < num_regs; i++)
            imem[num_random + i] = {op_rtype, 2'(i), 2'b00, 2'b00, fn_wwd};
        imem[prog_len - 1] = {op_rtype, 6'b000000, fn_hlt};
    endtask

    ////////////////////////////////////////////////////////////
    // ISA model
    task automatic model_step(input word_t inst, output logic is_wwd,
                              output logic is_hlt, output word_t wwd_val);
        word_t      a;
        word_t      b;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [7:0] imm8;
        rs      = inst[11:10];
        rt      = inst[9:8];
        rd      = inst[7:6];
        imm8    = inst[7:0];
        a       = model_regs[rs];
        b       = model_regs[rt];
        is_wwd  = 1'b0;
        is_hlt  = 1'b0;
        wwd_val = '0;
        case (inst[15:12])
            4'd4: model_regs[rt] = a + {{8{imm8[7]}}, imm8};
            4'd5: model_regs[rt] = a | {8'h00, imm8};
            4'd6: model_regs[rt] = {imm8, 8'h00};
            4'd15: begin
                case (inst[5:0])
                    6'd0: model_regs[rd] = a + b;
                    6'd1: model_regs[rd] = a - b;
                    6'd2: model_regs[rd] = a & b;
                    6'd3: model_regs[rd] = a | b;
                    6'd4: model_regs[rd] = ~a;
                    6'd5: model_regs[rd] = 16'd0 - a;
                    6'd6: model_regs[rd] = a << 1;
                    6'd7: model_regs[rd] = $signed(a) >>> 1;   // Sign kept
                    6'd28: begin
                        is_wwd  = 1'b1;
                        wwd_val = a;
                    end
                    6'd29: is_hlt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    endtask

    task automatic wait_retire(input word_t last, output logic timed_out);
        int   cycles;
        logic seen;
        cycles    = 0;
        seen      = 1'b0;
        timed_out = 1'b0;
        while (!seen && !timed_out) begin
            next_cycle();
            cycles++;
            if (num_inst != last)
                seen = 1'b1;
            else if (cycles >= timeout_cycles)
                timed_out = 1'b1;
        end
    endtask

    initial begin
        word_t last;
        word_t exp_out;
        logic  timed_out;
        logic  is_wwd;
        logic  is_hlt;
        int    idx;
        reset_n   = 1'b1;
        inst_data = '0;
        model_regs = '{default: '0};
        build_program();
        repeat (10) next_cycle();
        reset_n = 1'b0;

        check_value("num_inst", num_inst, 16'd0);
        check_value("is_halted", is_halted, 16'd0);
        check_value("read_inst", read_inst, 16'd1);
        check_value("inst_addr", inst_addr, 16'd0);

        last      = '0;
        idx       = 0;
        timed_out = 1'b0;
        while (idx < prog_len && !timed_out) begin
            wait_retire(last, timed_out);
            if (timed_out) begin
                timeouts++;
                $display("No instruction retired for %0d cycles after %0d retirements",
                         timeout_cycles, idx);
            end else begin
                check_value("num_inst", num_inst, last + 16'd1);
                model_step(imem[idx], is_wwd, is_hlt, exp_out);
                if (is_wwd)
                    check_value("output_port", output_port, exp_out);
                check_value("is_halted", is_halted, is_hlt);
                last = num_inst;
                idx++;
            end
        end

        // Core stays parked after HLT, PC on the word behind it
        if (!timed_out) begin
            check_value("num_inst", num_inst, prog_len);
            check_value("read_inst", read_inst, 16'd0);
            check_value("inst_addr", inst_addr, prog_len);
            repeat (20) begin
                next_cycle();
                check_value("is_halted", is_halted, 16'd1);
                check_value("read_inst", read_inst, 16'd0);
                check_value("num_inst", num_inst, prog_len);
                check_value("inst_addr", inst_addr, prog_len);
            end
        end

        $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cpu_core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core_chk (
    input logic           clk,
    input logic           reset_n,
    input tsc_pkg::word_t inst_addr,
    input logic           read_inst,
    input tsc_pkg::word_t num_inst,
    input logic           is_halted
);

    ////////////////////////////////////////////////////////////
    // Halt is sticky until reset
    halt_held: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted)
        else $error("is_halted fell while the core was out of reset");

    // Retire counter steps by zero or one
    count_step: assert property (@(posedge clk) disable iff (reset_n)
        (num_inst == $past(num_inst)) || (num_inst == $past(num_inst) + 16'd1))
        else $error("num_inst changed by more than one in a cycle");

    ////////////////////////////////////////////////////////////
    // Fetch address frozen once fetch stops
    addr_hold: assert property (@(posedge clk) disable iff (reset_n)
        !read_inst |=> $stable(inst_addr))
        else $error("inst_addr moved while read_inst was low");

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic           clk,
    input  logic           reset_n,
    input  tsc_pkg::word_t inst_data,
    output tsc_pkg::word_t inst_addr,
    output logic           read_inst,
    output tsc_pkg::word_t output_port,
    output tsc_pkg::word_t num_inst,
    output logic           is_halted
);
    import tsc_pkg::*;

    word_t                if_inst;
    logic                 if_valid;
    logic                 fetch_en;
    logic                 fetch_kill;
    reg_addr_t            rs_addr;
    reg_addr_t            rt_addr;
    word_t                rs_data;
    word_t                rt_data;
    alu_op_e              alu_op;
    imm_kind_e            imm_kind;
    logic [imm_width-1:0] imm;
    logic                 fwd_a;
    logic                 fwd_b;
    logic                 ex_load;
    logic                 wr_en;
    reg_addr_t            wr_addr;
    word_t                wb_result;

    assign read_inst = fetch_en;    // Fetch runs until HLT

    pipeline_control i_pipeline_control (
        .clk         (clk),
        .reset_n     (reset_n),
        .if_inst     (if_inst),
        .if_valid    (if_valid),
        .wb_result   (wb_result),
        .fetch_en    (fetch_en),
        .fetch_kill  (fetch_kill),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .alu_op      (alu_op),
        .imm_kind    (imm_kind),
        .imm         (imm),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .ex_load     (ex_load),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    fetch_unit i_fetch_unit (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_en   (fetch_en),
        .fetch_kill (fetch_kill),
        .inst_data  (inst_data),
        .inst_addr  (inst_addr),
        .if_inst    (if_inst),
        .if_valid   (if_valid)
    );

    register_file i_register_file (
        .clk     (clk),
        .reset_n (reset_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wb_result),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_unit i_execute_unit (
        .clk       (clk),
        .reset_n   (reset_n),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .alu_op    (alu_op),
        .imm_kind  (imm_kind),
        .imm       (imm),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .ex_load   (ex_load),
        .wb_result (wb_result)
    );

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                          clk,
    input  logic                          reset_n,
    input  tsc_pkg::word_t                rs_data,
    input  tsc_pkg::word_t                rt_data,
    input  tsc_pkg::alu_op_e              alu_op,
    input  tsc_pkg::imm_kind_e            imm_kind,
    input  logic [tsc_pkg::imm_width-1:0] imm,
    input  logic                          fwd_a,
    input  logic                          fwd_b,
    input  logic                          ex_load,
    output tsc_pkg::word_t                wb_result
);
    import tsc_pkg::*;

    // ID/EX
    alu_op_e              op_q;
    imm_kind_e            kind_q;
    word_t                a_q;
    word_t                b_q;
    logic [imm_width-1:0] imm_q;

    word_t src_a;
    word_t src_b;
    word_t alu_out;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            op_q   <= alu_add;
            kind_q <= imm_none;
        end else if (ex_load) begin
            op_q   <= alu_op;
            kind_q <= imm_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_load) begin
            a_q   <= rs_data;
            b_q   <= rt_data;
            imm_q <= imm;
        end
    end

    ////////////////////////////////////////////////////////////
    // Operands
    always_comb begin
        src_a = fwd_a ? wb_result : a_q;
        if (kind_q == imm_high)
            src_a = '0;                 // LHI ignores rs
        case (kind_q)
            imm_sign: src_b = {{(word_width-imm_width){imm_q[imm_width-1]}}, imm_q};
            imm_zero: src_b = {{(word_width-imm_width){1'b0}}, imm_q};
            imm_high: src_b = {imm_q, {(word_width-imm_width){1'b0}}};
            default:  src_b = fwd_b ? wb_result : b_q;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ALU
    always_comb begin
        case (op_q)
            alu_add: alu_out = src_a + src_b;
            alu_sub: alu_out = src_a - src_b;
            alu_and: alu_out = src_a & src_b;
            alu_or:  alu_out = src_a | src_b;
            alu_not: alu_out = ~src_a;
            alu_tcp: alu_out = ~src_a + 1'b1;
            alu_shl: alu_out = {src_a[word_width-2:0], 1'b0};
            alu_shr: alu_out = {src_a[word_width-1], src_a[word_width-1:1]};  // Arithmetic
            default: alu_out = '0;
        endcase
    end

    // EX/WB result
    always_ff @(posedge clk) begin
        wb_result <= alu_out;
    end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  tsc_pkg::reg_addr_t rs_addr,
    input  tsc_pkg::reg_addr_t rt_addr,
    input  tsc_pkg::reg_addr_t wr_addr,
    input  logic               wr_en,
    input  tsc_pkg::word_t     wr_data,
    output tsc_pkg::word_t     rs_data,
    output tsc_pkg::word_t     rt_data
);
    import tsc_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset_n)
            regs <= '{default: '0};
        else if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    // Write-through, decode sees this cycle's write-back
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           fetch_en,
    input  logic           fetch_kill,
    input  tsc_pkg::word_t inst_data,
    output tsc_pkg::word_t inst_addr,
    output tsc_pkg::word_t if_inst,
    output logic           if_valid
);
    import tsc_pkg::*;

    word_t pc;

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else begin
            if (fetch_kill)
                if_valid <= 1'b0;
            else if (fetch_en)
                if_valid <= 1'b1;
            if (fetch_en)
                pc <= pc + 1'b1;    // Word addressed
        end
    end

    // IF/ID instruction
    always_ff @(posedge clk) begin
        if (fetch_en)
            if_inst <= inst_data;
    end

endmodule

`default_nettype wire

// ==== design/pipeline_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  logic                          clk,
    input  logic                          reset_n,
    input  tsc_pkg::word_t                if_inst,
    input  logic                          if_valid,
    input  tsc_pkg::word_t                wb_result,
    output logic                          fetch_en,
    output logic                          fetch_kill,
    output tsc_pkg::reg_addr_t            rs_addr,
    output tsc_pkg::reg_addr_t            rt_addr,
    output tsc_pkg::alu_op_e              alu_op,
    output tsc_pkg::imm_kind_e            imm_kind,
    output logic [tsc_pkg::imm_width-1:0] imm,
    output logic                          fwd_a,
    output logic                          fwd_b,
    output logic                          ex_load,
    output logic                          wr_en,
    output tsc_pkg::reg_addr_t            wr_addr,
    output tsc_pkg::word_t                output_port,
    output tsc_pkg::word_t                num_inst,
    output logic                          is_halted
);
    import tsc_pkg::*;

    opcode_e   dec_opcode;
    funct_e    dec_funct;
    reg_addr_t dec_dst;
    logic      dec_write;
    logic      dec_wwd;
    logic      dec_halt;
    logic      halt_in_id;
    logic      halt_pending;

    // ID/EX and EX/WB control
    logic      id_ex_valid, id_ex_write, id_ex_wwd, id_ex_halt;
    reg_addr_t id_ex_dst, id_ex_rs, id_ex_rt;
    logic      ex_wb_valid, ex_wb_write, ex_wb_wwd, ex_wb_halt;
    reg_addr_t ex_wb_dst;

    ////////////////////////////////////////////////////////////
    // Decode
    assign dec_opcode = opcode_e'(if_inst[opcode_msb:opcode_lsb]);
    assign dec_funct  = funct_e'(if_inst[funct_msb:funct_lsb]);
    assign rs_addr    = if_inst[rs_msb:rs_lsb];
    assign rt_addr    = if_inst[rt_msb:rt_lsb];
    assign imm        = dec_wwd ? '0 : if_inst[imm_msb:imm_lsb];  // WWD adds zero

    always_comb begin
        alu_op    = alu_add;
        imm_kind  = imm_none;
        dec_dst   = if_inst[rt_msb:rt_lsb];
        dec_write = 1'b0;
        dec_wwd   = 1'b0;
        dec_halt  = 1'b0;
        case (dec_opcode)
            op_adi: begin
                imm_kind  = imm_sign;
                dec_write = 1'b1;
            end
            op_ori: begin
                alu_op    = alu_or;
                imm_kind  = imm_zero;
                dec_write = 1'b1;
            end
            op_lhi: begin
                imm_kind  = imm_high;
                dec_write = 1'b1;
            end
            op_rtype: begin
                dec_dst = if_inst[rd_msb:rd_lsb];
                case (dec_funct)
                    fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
                        alu_op    = alu_op_e'(dec_funct[2:0]);
                        dec_write = 1'b1;
                    end
                    fn_wwd: begin
                        imm_kind = imm_zero;
                        dec_wwd  = 1'b1;
                    end
                    fn_hlt: dec_halt = 1'b1;
                    default: ;      // No-op
                endcase
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Fetch control
    assign halt_in_id = if_valid && dec_halt;
    assign fetch_en   = !(halt_in_id || halt_pending);
    assign fetch_kill = halt_in_id;     // Drop the word behind HLT
    assign ex_load    = if_valid;

    // Write-back result into execute
    assign fwd_a   = ex_wb_write && (ex_wb_dst == id_ex_rs);
    assign fwd_b   = ex_wb_write && (ex_wb_dst == id_ex_rt);
    assign wr_en   = ex_wb_write;
    assign wr_addr = ex_wb_dst;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_pending <= 1'b0;
            id_ex_valid  <= 1'b0;
            id_ex_write  <= 1'b0;
            id_ex_wwd    <= 1'b0;
            id_ex_halt   <= 1'b0;
            ex_wb_valid  <= 1'b0;
            ex_wb_write  <= 1'b0;
            ex_wb_wwd    <= 1'b0;
            ex_wb_halt   <= 1'b0;
            num_inst     <= '0;
            output_port  <= '0;
            is_halted    <= 1'b0;
        end else begin
            if (halt_in_id)
                halt_pending <= 1'b1;
            id_ex_valid <= if_valid;
            id_ex_write <= if_valid && dec_write;
            id_ex_wwd   <= if_valid && dec_wwd;
            id_ex_halt  <= halt_in_id;
            ex_wb_valid <= id_ex_valid;
            ex_wb_write <= id_ex_write;
            ex_wb_wwd   <= id_ex_wwd;
            ex_wb_halt  <= id_ex_halt;

            // Retire
            if (ex_wb_valid)
                num_inst <= num_inst + 1'b1;
            if (ex_wb_wwd)
                output_port <= wb_result;
            if (ex_wb_halt)
                is_halted <= 1'b1;  // Held until reset
        end
    end

    always_ff @(posedge clk) begin
        id_ex_dst <= dec_dst;
        id_ex_rs  <= rs_addr;
        id_ex_rt  <= rt_addr;
        ex_wb_dst <= id_ex_dst;
    end

endmodule

`default_nettype wire

// ==== design/tsc_pkg.sv ====
`default_nettype none

package tsc_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    localparam int word_width     = 16;
    localparam int reg_addr_width = 2;
    localparam int num_regs       = 4;
    localparam int imm_width      = 8;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;
    localparam int rs_msb     = 11;
    localparam int rs_lsb     = 10;
    localparam int rt_msb     = 9;
    localparam int rt_lsb     = 8;
    localparam int rd_msb     = 7;
    localparam int rd_lsb     = 6;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;
    localparam int imm_msb    = 7;
    localparam int imm_lsb    = 0;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    typedef enum logic [opcode_msb-opcode_lsb:0] {
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_rtype = 4'd15
    } opcode_e;

    typedef enum logic [funct_msb-funct_lsb:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,
        fn_shl = 6'd6,
        fn_shr = 6'd7,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } funct_e;

    // Same order as function codes 0..7
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_tcp,
        alu_shl,
        alu_shr
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_none,   // Register B
        imm_sign,
        imm_zero,
        imm_high
    } imm_kind_e;

endpackage

`default_nettype wire
